// File: logic/issue_pkg.sv
package issue_pkg;

	localparam int NUM_WARPS = 4;
	localparam int WARP_W = 2;
	localparam int NUM_REGS = 32;
	localparam int REG_W = 5;
	localparam int XLEN = 32;
	localparam int ALU_LAT = 3; // Issue cycle to wb_valid.
	localparam int LSU_LAT = 4; // Memory access time.
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW = $clog2(DMEM_WORDS);
	localparam int LSU_CNT_W = $clog2(LSU_LAT + 1);
	localparam int OFF_W = 13; // Low field of the instruction word.

	localparam logic [3:0] OP_NOP = 4'h0;
	localparam logic [3:0] OP_ADD = 4'h1;
	localparam logic [3:0] OP_ADDI = 4'h2;
	localparam logic [3:0] OP_LW = 4'h3;
	localparam logic [3:0] OP_SW = 4'h4;

	typedef struct packed {
		logic [3:0] opcode;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic signed [OFF_W-1:0] imm; // Added to rs1 by ADDI.
	} alu_view_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic signed [OFF_W-1:0] offset; // Word offset from rs1.
	} mem_view_t;

	typedef union packed {
		alu_view_t alu;
		mem_view_t mem;
	} instr_word_u;

endpackage

// File: logic/warp_scoreboard.sv
`timescale 1ns/100ps

module warp_scoreboard (
	input logic clk,
	input logic reset,
	input logic [issue_pkg::WARP_W-1:0] chk_warp,
	input logic [issue_pkg::REG_W-1:0] chk_rs1,
	input logic [issue_pkg::REG_W-1:0] chk_rs2,
	input logic [issue_pkg::REG_W-1:0] chk_rd,
	input logic uses_rs2,
	input logic writes_rd,
	input logic issue_fire,
	input logic wb_valid,
	input logic [issue_pkg::WARP_W-1:0] wb_warp,
	input logic [issue_pkg::REG_W-1:0] wb_rd,
	output logic hazard
);

	import issue_pkg::*;

	logic [NUM_REGS-1:0] pending [NUM_WARPS]; // One bit per register with a write in flight.
	logic rs1_busy;
	logic rs2_busy;
	logic rd_busy;
	logic set_en;
	logic clr_en;

	assign rs1_busy = pending[chk_warp][chk_rs1] && (chk_rs1 != '0);
	assign rs2_busy = uses_rs2 && pending[chk_warp][chk_rs2] && (chk_rs2 != '0);

	// ALU results may pass a slow load, so an rd still owed is a hazard too.
	assign rd_busy = writes_rd && pending[chk_warp][chk_rd] && (chk_rd != '0);

	assign hazard = rs1_busy || rs2_busy || rd_busy;

	assign set_en = issue_fire && writes_rd && (chk_rd != '0);
	assign clr_en = wb_valid && (wb_rd != '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int w = 0; w < NUM_WARPS; w++) begin
				pending[w] <= '0;
			end
		end else begin
			if (clr_en) begin
				pending[wb_warp][wb_rd] <= 1'b0;
			end
			if (set_en) begin
				pending[chk_warp][chk_rd] <= 1'b1; // Set wins over a clear of the same bit.
			end
		end
	end

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/100ps

module issue_stage (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic [issue_pkg::WARP_W-1:0] instr_warp,
	input logic [issue_pkg::XLEN-1:0] instr_word,
	output logic instr_ready,
	output logic [issue_pkg::REG_W-1:0] sb_rs1,
	output logic [issue_pkg::REG_W-1:0] sb_rs2,
	output logic [issue_pkg::REG_W-1:0] sb_rd,
	output logic sb_uses_rs2,
	output logic sb_writes_rd,
	output logic issue_fire,
	input logic hazard,
	output logic [issue_pkg::REG_W-1:0] rd_addr_a,
	output logic [issue_pkg::REG_W-1:0] rd_addr_b,
	input logic [issue_pkg::XLEN-1:0] rd_data_a,
	input logic [issue_pkg::XLEN-1:0] rd_data_b,
	input logic lsu_busy,
	output logic alu_valid,
	output logic [issue_pkg::WARP_W-1:0] alu_warp,
	output logic [issue_pkg::REG_W-1:0] alu_rd,
	output logic [issue_pkg::XLEN-1:0] alu_a,
	output logic [issue_pkg::XLEN-1:0] alu_b,
	output logic lsu_valid,
	output logic lsu_store,
	output logic [issue_pkg::WARP_W-1:0] lsu_warp,
	output logic [issue_pkg::REG_W-1:0] lsu_rd,
	output logic [issue_pkg::XLEN-1:0] lsu_addr,
	output logic [issue_pkg::XLEN-1:0] lsu_wdata
);

	import issue_pkg::*;

	instr_word_u iw;
	logic [3:0] opc;
	logic is_alu;
	logic is_load;
	logic is_store;
	logic is_mem;
	logic ready_en; // Holds ready low until the first cycle after reset.

	assign iw = instr_word;
	assign opc = iw.alu.opcode;

	assign is_alu = (opc == OP_ADD) || (opc == OP_ADDI);
	assign is_load = (opc == OP_LW);
	assign is_store = (opc == OP_SW);
	assign is_mem = is_load || is_store;

	assign sb_rs1 = iw.alu.rs1;
	assign sb_rs2 = iw.alu.rs2;
	assign sb_rd = iw.alu.rd;
	assign sb_uses_rs2 = (opc == OP_ADD) || is_store;
	assign sb_writes_rd = is_alu || is_load;
	assign rd_addr_a = iw.alu.rs1;
	assign rd_addr_b = iw.alu.rs2;

	// lsu_valid covers the cycle before lsu_busy is seen.
	assign instr_ready = ready_en && !hazard && !lsu_valid && !(is_mem && lsu_busy);
	assign issue_fire = instr_valid && instr_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ready_en <= 1'b0;
			alu_valid <= 1'b0;
			lsu_valid <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			alu_valid <= issue_fire && is_alu && (iw.alu.rd != '0); // Add to r0 is a no-op.
			lsu_valid <= issue_fire && is_mem;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_fire) begin
			alu_warp <= instr_warp;
			alu_rd <= iw.alu.rd;
			alu_a <= rd_data_a;
			alu_b <= sb_uses_rs2 ? rd_data_b : XLEN'(iw.alu.imm);
			lsu_store <= is_store;
			lsu_warp <= instr_warp;
			lsu_rd <= iw.mem.rd;
			lsu_addr <= rd_data_a + XLEN'(iw.mem.offset);
			lsu_wdata <= rd_data_b;
		end
	end

endmodule

// File: logic/warp_gpr_file.sv
`timescale 1ns/100ps

module warp_gpr_file (
	input logic clk,
	input logic reset,
	input logic [issue_pkg::WARP_W-1:0] rd_warp,
	input logic [issue_pkg::REG_W-1:0] rd_addr_a,
	input logic [issue_pkg::REG_W-1:0] rd_addr_b,
	output logic [issue_pkg::XLEN-1:0] rd_data_a,
	output logic [issue_pkg::XLEN-1:0] rd_data_b,
	input logic wr_en,
	input logic [issue_pkg::WARP_W-1:0] wr_warp,
	input logic [issue_pkg::REG_W-1:0] wr_addr,
	input logic [issue_pkg::XLEN-1:0] wr_data
);

	import issue_pkg::*;

	logic [XLEN-1:0] regs [NUM_WARPS][NUM_REGS]; // One bank per warp.

	assign rd_data_a = regs[rd_warp][rd_addr_a];
	assign rd_data_b = regs[rd_warp][rd_addr_b];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int w = 0; w < NUM_WARPS; w++) begin
				for (int r = 0; r < NUM_REGS; r++) begin
					regs[w][r] <= '0;
				end
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_warp][wr_addr] <= wr_data; // r0 stays zero.
		end
	end

endmodule

// File: logic/alu_pipe.sv
`timescale 1ns/100ps

module alu_pipe (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [issue_pkg::WARP_W-1:0] in_warp,
	input logic [issue_pkg::REG_W-1:0] in_rd,
	input logic [issue_pkg::XLEN-1:0] in_a,
	input logic [issue_pkg::XLEN-1:0] in_b,
	output logic res_valid,
	output logic [issue_pkg::WARP_W-1:0] res_warp,
	output logic [issue_pkg::REG_W-1:0] res_rd,
	output logic [issue_pkg::XLEN-1:0] res_data
);

	import issue_pkg::*;

	// The writeback register is the last of the ALU_LAT stages.
	logic [ALU_LAT-2:0] valid_sr;
	logic [WARP_W-1:0] warp_sr [ALU_LAT-1];
	logic [REG_W-1:0] rd_sr [ALU_LAT-1];
	logic [XLEN-1:0] data_sr [ALU_LAT-1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_sr <= '0;
		end else begin
			valid_sr[0] <= in_valid;
			for (int i = 1; i < ALU_LAT - 1; i++) begin
				valid_sr[i] <= valid_sr[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		warp_sr[0] <= in_warp;
		rd_sr[0] <= in_rd;
		data_sr[0] <= in_a + in_b; // Sum is formed in the first stage.
		for (int i = 1; i < ALU_LAT - 1; i++) begin
			warp_sr[i] <= warp_sr[i-1];
			rd_sr[i] <= rd_sr[i-1];
			data_sr[i] <= data_sr[i-1];
		end
	end

	assign res_valid = valid_sr[ALU_LAT-2];
	assign res_warp = warp_sr[ALU_LAT-2];
	assign res_rd = rd_sr[ALU_LAT-2];
	assign res_data = data_sr[ALU_LAT-2];

endmodule

// File: logic/lsu_unit.sv
`timescale 1ns/100ps

module lsu_unit (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input logic req_store,
	input logic [issue_pkg::WARP_W-1:0] req_warp,
	input logic [issue_pkg::REG_W-1:0] req_rd,
	input logic [issue_pkg::XLEN-1:0] req_addr,
	input logic [issue_pkg::XLEN-1:0] req_wdata,
	output logic busy,
	output logic res_valid,
	output logic [issue_pkg::WARP_W-1:0] res_warp,
	output logic [issue_pkg::REG_W-1:0] res_rd,
	output logic [issue_pkg::XLEN-1:0] res_data,
	input logic res_ack
);

	import issue_pkg::*;

	logic [XLEN-1:0] dmem [DMEM_WORDS];
	logic [LSU_CNT_W-1:0] cnt;
	logic store_q;
	logic [DMEM_AW-1:0] addr_q; // Address wraps at the memory size.
	logic [XLEN-1:0] wdata_q;
	logic accept;
	logic done;

	assign accept = req_valid && !busy;
	assign done = busy && !res_valid && (cnt == LSU_CNT_W'(1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			res_valid <= 1'b0;
			cnt <= '0;
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else begin
			if (accept) begin
				busy <= 1'b1;
				cnt <= LSU_CNT_W'(LSU_LAT);
			end else if (busy && !res_valid) begin
				cnt <= cnt - 1'b1;
			end
			if (done && store_q) begin
				dmem[addr_q] <= wdata_q;
				busy <= 1'b0; // Store needs no writeback.
			end
			if (done && !store_q) begin
				res_valid <= 1'b1;
			end
			if (res_valid && res_ack) begin
				res_valid <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			store_q <= req_store;
			res_warp <= req_warp;
			res_rd <= req_rd;
			addr_q <= req_addr[DMEM_AW-1:0];
			wdata_q <= req_wdata;
		end
		if (done && !store_q) begin
			res_data <= dmem[addr_q];
		end
	end

endmodule

// File: logic/writeback_mux.sv
`timescale 1ns/100ps

module writeback_mux (
	input logic clk,
	input logic reset,
	input logic alu_res_valid,
	input logic [issue_pkg::WARP_W-1:0] alu_res_warp,
	input logic [issue_pkg::REG_W-1:0] alu_res_rd,
	input logic [issue_pkg::XLEN-1:0] alu_res_data,
	input logic lsu_res_valid,
	input logic [issue_pkg::WARP_W-1:0] lsu_res_warp,
	input logic [issue_pkg::REG_W-1:0] lsu_res_rd,
	input logic [issue_pkg::XLEN-1:0] lsu_res_data,
	output logic lsu_res_ack,
	output logic wb_valid,
	output logic [issue_pkg::WARP_W-1:0] wb_warp,
	output logic [issue_pkg::REG_W-1:0] wb_rd,
	output logic [issue_pkg::XLEN-1:0] wb_data
);

	logic lsu_win;

	assign lsu_win = lsu_res_valid && !alu_res_valid; // ALU cannot stall, so it goes first.
	assign lsu_res_ack = lsu_win;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			// Loads into r0 retire here without a register write.
			wb_valid <= (alu_res_valid && (alu_res_rd != '0)) ||
				(lsu_win && (lsu_res_rd != '0));
		end
	end

	always_ff @(posedge clk) begin
		if (alu_res_valid) begin
			wb_warp <= alu_res_warp;
			wb_rd <= alu_res_rd;
			wb_data <= alu_res_data;
		end else begin
			wb_warp <= lsu_res_warp;
			wb_rd <= lsu_res_rd;
			wb_data <= lsu_res_data;
		end
	end

endmodule

// File: logic/issue_top.sv
`timescale 1ns/100ps

module issue_top (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic [issue_pkg::WARP_W-1:0] instr_warp,
	input logic [issue_pkg::XLEN-1:0] instr_word,
	output logic instr_ready,
	output logic wb_valid,
	output logic [issue_pkg::WARP_W-1:0] wb_warp,
	output logic [issue_pkg::REG_W-1:0] wb_rd,
	output logic [issue_pkg::XLEN-1:0] wb_data
);

	import issue_pkg::*;

	logic [REG_W-1:0] sb_rs1, sb_rs2, sb_rd;
	logic sb_uses_rs2, sb_writes_rd, issue_fire, hazard;
	logic [REG_W-1:0] rd_addr_a, rd_addr_b;
	logic [XLEN-1:0] rd_data_a, rd_data_b;
	logic alu_valid, lsu_valid, lsu_store, lsu_busy, lsu_res_ack;
	logic [WARP_W-1:0] alu_warp, lsu_warp;
	logic [REG_W-1:0] alu_rd, lsu_rd;
	logic [XLEN-1:0] alu_a, alu_b, lsu_addr, lsu_wdata;
	logic alu_res_valid, lsu_res_valid;
	logic [WARP_W-1:0] alu_res_warp, lsu_res_warp;
	logic [REG_W-1:0] alu_res_rd, lsu_res_rd;
	logic [XLEN-1:0] alu_res_data, lsu_res_data;

	issue_stage u_issue (.clk, .reset, .instr_valid, .instr_warp, .instr_word, .instr_ready,
		.sb_rs1, .sb_rs2, .sb_rd, .sb_uses_rs2, .sb_writes_rd, .issue_fire, .hazard,
		.rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b, .lsu_busy,
		.alu_valid, .alu_warp, .alu_rd, .alu_a, .alu_b,
		.lsu_valid, .lsu_store, .lsu_warp, .lsu_rd, .lsu_addr, .lsu_wdata);

	warp_scoreboard u_sb (.clk, .reset, .chk_warp(instr_warp), .chk_rs1(sb_rs1),
		.chk_rs2(sb_rs2), .chk_rd(sb_rd), .uses_rs2(sb_uses_rs2), .writes_rd(sb_writes_rd),
		.issue_fire, .wb_valid, .wb_warp, .wb_rd, .hazard);

	warp_gpr_file u_gpr (.clk, .reset, .rd_warp(instr_warp), .rd_addr_a, .rd_addr_b,
		.rd_data_a, .rd_data_b, .wr_en(wb_valid), .wr_warp(wb_warp), .wr_addr(wb_rd),
		.wr_data(wb_data));

	alu_pipe u_alu (.clk, .reset, .in_valid(alu_valid), .in_warp(alu_warp), .in_rd(alu_rd),
		.in_a(alu_a), .in_b(alu_b), .res_valid(alu_res_valid), .res_warp(alu_res_warp),
		.res_rd(alu_res_rd), .res_data(alu_res_data));

	lsu_unit u_lsu (.clk, .reset, .req_valid(lsu_valid), .req_store(lsu_store),
		.req_warp(lsu_warp), .req_rd(lsu_rd), .req_addr(lsu_addr), .req_wdata(lsu_wdata),
		.busy(lsu_busy), .res_valid(lsu_res_valid), .res_warp(lsu_res_warp),
		.res_rd(lsu_res_rd), .res_data(lsu_res_data), .res_ack(lsu_res_ack));

	writeback_mux u_wb (.clk, .reset, .alu_res_valid, .alu_res_warp, .alu_res_rd,
		.alu_res_data, .lsu_res_valid, .lsu_res_warp, .lsu_res_rd, .lsu_res_data,
		.lsu_res_ack, .wb_valid, .wb_warp, .wb_rd, .wb_data);

endmodule

// File: tb/scoreboard_checker.sv
`timescale 1ns/100ps

module scoreboard_checker (
	input logic clk,
	input logic reset,
	input logic [issue_pkg::WARP_W-1:0] chk_warp,
	input logic [issue_pkg::REG_W-1:0] chk_rd,
	input logic writes_rd,
	input logic issue_fire,
	input logic hazard,
	input logic wb_valid,
	input logic [issue_pkg::WARP_W-1:0] wb_warp,
	input logic [issue_pkg::REG_W-1:0] wb_rd,
	input logic [issue_pkg::NUM_REGS-1:0] pending [issue_pkg::NUM_WARPS]
);

	no_issue_on_hazard: assert property (@(posedge clk) disable iff (reset)
		!(hazard && issue_fire))
		else $error("issue_fire asserted while hazard is high");

	// Sampled values are the ones before the edge.
	set_only_clear_bit: assert property (@(posedge clk) disable iff (reset)
		(issue_fire && writes_rd && chk_rd != '0) |-> !pending[chk_warp][chk_rd])
		else $error("issued rd already had a pending write");

	clear_only_set_bit: assert property (@(posedge clk) disable iff (reset)
		(wb_valid && wb_rd != '0) |-> pending[wb_warp][wb_rd])
		else $error("writeback cleared a bit that was not set");

endmodule

bind warp_scoreboard scoreboard_checker u_sb_chk (.clk, .reset, .chk_warp, .chk_rd,
	.writes_rd, .issue_fire, .hazard, .wb_valid, .wb_warp, .wb_rd, .pending);

// File: tb/issue_tb.sv
`timescale 1ns/100ps

module issue_tb;

	import issue_pkg::*;

	localparam int NUM_INSTR = 200;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * (LSU_LAT + 6) + 500;

	typedef struct packed {
		logic [XLEN-1:0] value;
		int t_cyc; // Sample cycle of the transfer.
		logic is_load;
	} due_t;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [WARP_W-1:0] instr_warp;
	logic [XLEN-1:0] instr_word;
	logic instr_ready;
	logic wb_valid;
	logic [WARP_W-1:0] wb_warp;
	logic [REG_W-1:0] wb_rd;
	logic [XLEN-1:0] wb_data;
	logic xfer;

	logic [WARP_W-1:0] prog_warp [$];
	instr_word_u prog_word [$];
	logic [XLEN-1:0] model_regs [NUM_WARPS][NUM_REGS];
	logic [XLEN-1:0] model_mem [DMEM_WORDS];
	due_t due_q [NUM_WARPS][NUM_REGS][$]; // Writes still owed, oldest first.

	int cyc = 0;
	int due_count = 0;
	int loads_due = 0;
	int last_mem_cyc = -100;
	int accepted = 0;
	int wb_count = 0;
	int data_errors = 0;
	int timing_errors = 0;
	int protocol_errors = 0;

	issue_top UUT (.clk, .reset, .instr_valid, .instr_warp, .instr_word, .instr_ready,
		.wb_valid, .wb_warp, .wb_rd, .wb_data);

	assign xfer = instr_valid && instr_ready && !reset;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic instr_word_u encode(input logic [3:0] op, input int rd, input int rs1,
		input int rs2, input int imm);
		instr_word_u u;
		u = '0;
		u.alu.opcode = op;
		u.alu.rd = REG_W'(rd);
		u.alu.rs1 = REG_W'(rs1);
		u.alu.rs2 = REG_W'(rs2);
		if (op == OP_LW || op == OP_SW) begin
			u.mem.offset = OFF_W'(imm);
		end else begin
			u.alu.imm = OFF_W'(imm);
		end
		return u;
	endfunction

	// Few registers, so dependences come often.
	function automatic instr_word_u random_instr();
		logic [3:0] op;
		case ($urandom_range(0, 9))
			0: op = OP_NOP;
			1, 2, 3: op = OP_ADD;
			4, 5: op = OP_ADDI;
			6, 7: op = OP_LW;
			default: op = OP_SW;
		endcase
		return encode(op, $urandom_range(0, 4), $urandom_range(0, 4), $urandom_range(0, 4),
			int'($urandom_range(0, 40)) - 20);
	endfunction

	function automatic logic [XLEN-1:0] sext_low(input logic [OFF_W-1:0] v);
		return {{(XLEN - OFF_W){v[OFF_W-1]}}, v};
	endfunction

	// Sequential execution of one accepted instruction over the model state.
	function automatic logic [XLEN-1:0] exec_model(input logic [WARP_W-1:0] w,
		input instr_word_u iw);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] res;
		logic [XLEN-1:0] ea;
		a = model_regs[w][iw.alu.rs1];
		b = model_regs[w][iw.alu.rs2];
		ea = a + sext_low(iw.mem.offset);
		res = '0;
		case (iw.alu.opcode)
			OP_ADD: res = a + b;
			OP_ADDI: res = a + sext_low(iw.alu.imm);
			OP_LW: res = model_mem[ea % DMEM_WORDS];
			OP_SW: model_mem[ea % DMEM_WORDS] = b;
			default: res = '0;
		endcase
		if (iw.alu.opcode inside {OP_ADD, OP_ADDI, OP_LW} && iw.alu.rd != '0) begin
			model_regs[w][iw.alu.rd] = res;
		end
		return res;
	endfunction

	function automatic logic still_due(input logic [WARP_W-1:0] w, input logic [REG_W-1:0] r);
		return (r != '0) && (due_q[w][r].size() != 0);
	endfunction

	task automatic check_order(input logic [WARP_W-1:0] w, input instr_word_u iw);
		logic [3:0] opc;
		logic hit;
		opc = iw.alu.opcode;
		hit = (opc != OP_NOP) && still_due(w, iw.alu.rs1);
		hit = hit || ((opc == OP_ADD || opc == OP_SW) && still_due(w, iw.alu.rs2));
		hit = hit || (opc inside {OP_ADD, OP_ADDI, OP_LW} && still_due(w, iw.alu.rd));
		if (hit) begin
			protocol_errors++;
			$display("Instruction on warp %0d accepted at %0t ns before an owed write retired",
				w, $time);
		end
	endtask

	task automatic compare_writeback();
		due_t e;
		int lat;
		wb_count++;
		if (wb_rd == '0) begin
			data_errors++;
			$display("Error at %0t ns: writeback to register 0 on warp %0d", $time, wb_warp);
		end else if (due_q[wb_warp][wb_rd].size() == 0) begin
			data_errors++;
			$display("Error at %0t ns: unexpected writeback warp %0d r%0d", $time, wb_warp, wb_rd);
		end else begin
			e = due_q[wb_warp][wb_rd].pop_front();
			due_count--;
			if (e.is_load) loads_due--;
			if (wb_data !== e.value) begin
				data_errors++;
				$display("Error at %0t ns: warp %0d r%0d data %h, expected %h", $time,
					wb_warp, wb_rd, wb_data, e.value);
			end
			lat = cyc - e.t_cyc - 1; // wb_valid rose at the edge before this sample.
			if ((!e.is_load && lat != ALU_LAT) || (e.is_load && lat < LSU_LAT + 1)) begin
				timing_errors++;
				$display("Error at %0t ns: warp %0d r%0d latency %0d cycles", $time,
					wb_warp, wb_rd, lat);
			end
		end
	endtask

	task automatic record_issue(input logic [WARP_W-1:0] w, input instr_word_u iw);
		due_t e;
		logic [3:0] opc;
		logic is_mem;
		opc = iw.alu.opcode;
		is_mem = (opc == OP_LW) || (opc == OP_SW);
		if (is_mem && (loads_due != 0 || cyc - last_mem_cyc <= LSU_LAT + 1)) begin
			protocol_errors++;
			$display("Memory instruction accepted at %0t ns while the LSU was still busy", $time);
		end
		if (is_mem) last_mem_cyc = cyc;
		e.value = exec_model(w, iw);
		e.t_cyc = cyc;
		e.is_load = (opc == OP_LW);
		if (opc inside {OP_ADD, OP_ADDI, OP_LW} && iw.alu.rd != '0) begin
			due_q[w][iw.alu.rd].push_back(e);
			due_count++;
			if (e.is_load) loads_due++;
		end
		accepted++;
	endtask

	// Inputs change 2 ns after the rising edge, so the falling edge sees settled values.
	always @(negedge clk) begin
		if (xfer) check_order(instr_warp, instr_word);
		if (wb_valid && !reset) compare_writeback();
		if (xfer) record_issue(instr_warp, instr_word);
	end

	task automatic add_instr(input int w, input instr_word_u iw);
		prog_warp.push_back(WARP_W'(w));
		prog_word.push_back(iw);
	endtask

	task automatic build_program();
		add_instr(0, encode(OP_ADDI, 1, 0, 0, 100));
		add_instr(0, encode(OP_SW, 0, 1, 1, -40)); // Word 60.
		add_instr(0, encode(OP_LW, 2, 1, 0, -40));
		add_instr(0, encode(OP_ADD, 3, 2, 1, 0)); // Depends on the load.
		add_instr(1, encode(OP_ADDI, 1, 0, 0, 5));
		add_instr(0, encode(OP_SW, 0, 0, 3, -3)); // Wraps to word 61.
		add_instr(0, encode(OP_LW, 4, 0, 0, 125));
		add_instr(0, encode(OP_ADDI, 4, 0, 0, 7)); // Second write to r4 behind the load.
		add_instr(0, encode(OP_ADDI, 0, 1, 0, 1));
		add_instr(1, encode(OP_ADD, 2, 0, 1, 0));
		while (prog_word.size() < NUM_INSTR) begin
			add_instr($urandom_range(0, NUM_WARPS - 1), random_instr());
		end
	endtask

	initial begin
		void'($urandom(32'h7909));
		reset = 1'b1;
		instr_valid = 1'b0;
		instr_warp = '0;
		instr_word = '0;
		for (int w = 0; w < NUM_WARPS; w++) begin
			for (int r = 0; r < NUM_REGS; r++) model_regs[w][r] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) model_mem[i] = '0;
		build_program();
		repeat (16) @(posedge clk);
		#2;
		if (instr_ready || wb_valid) begin
			protocol_errors++;
			$display("Error at %0t ns: instr_ready or wb_valid high during reset", $time);
		end
		reset = 1'b0;
		for (int i = 0; i < prog_word.size(); i++) begin
			if ($urandom_range(0, 3) == 0) begin
				instr_valid = 1'b0;
				repeat ($urandom_range(1, 3)) @(posedge clk);
				#2;
			end
			instr_valid = 1'b1;
			instr_warp = prog_warp[i];
			instr_word = prog_word[i];
			do begin
				@(negedge clk);
			end while (!instr_ready);
			@(posedge clk);
			#2;
		end
		instr_valid = 1'b0;
		wait (due_count == 0);
		repeat (ALU_LAT + LSU_LAT + 4) @(posedge clk);
		$display("Accepted %0d, writebacks %0d, data errors %0d, timing errors %0d, %0s %0d",
			accepted, wb_count, data_errors, timing_errors, "protocol errors", protocol_errors);
		if (data_errors + timing_errors + protocol_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		while (cyc < TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles with %0d writes still owed", cyc, due_count);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: filelist.f
logic/issue_pkg.sv
logic/warp_scoreboard.sv
logic/issue_stage.sv
logic/warp_gpr_file.sv
logic/alu_pipe.sv
logic/lsu_unit.sv
logic/writeback_mux.sv
logic/issue_top.sv
tb/scoreboard_checker.sv
tb/issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the issue subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module issue_tb \
	-f filelist.f -Mdir obj_dir -o issue_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/issue_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
fi
exit 1
